// ==== Makefile ====
# Verilator simulation of the upsampler testbench

BIN := obj_dir/Vupsampler_tb

.PHONY: all run clean

all: run

$(BIN): sim.f $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing -Wno-fatal -f sim.f --top-module upsampler_tb -o Vupsampler_tb

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== logic/boxcar_smoother.sv ====
`timescale 1ns/10ps
`default_nettype none

module boxcar_smoother
  import sample_pkg::*, rate_pkg::*;
#(
  parameter int LOG2_TAPS = 2
)
(
  input  logic         aclk,
  input  logic         aresetn,
  input  rate_cfg_t    cfg,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  output logic         s_ready,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready
);

  localparam int TAPS  = 2**LOG2_TAPS;
  localparam int SUM_W = SAMPLE_W + LOG2_TAPS;               // Sum of TAPS samples cannot overflow

  sample_t                 hist [TAPS];
  logic signed [SUM_W-1:0] sum_reg;
  logic signed [SUM_W-1:0] sum_next;
  logic signed [SUM_W-1:0] avg;
  logic [SUM_W-1:0]        new_ext;
  logic [SUM_W-1:0]        old_ext;
  logic                    in_xfer;
  stream_beat_t            out_beat;
  logic                    out_valid;

  assign s_ready = ~out_valid | m_ready;
  assign in_xfer = s_valid & s_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Running sum
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign new_ext  = {{LOG2_TAPS{s_beat.sample[SAMPLE_W-1]}}, s_beat.sample};
  assign old_ext  = {{LOG2_TAPS{hist[TAPS-1][SAMPLE_W-1]}}, hist[TAPS-1]};
  assign sum_next = sum_reg + new_ext - old_ext;             // Oldest sample leaves the window
  assign avg      = sum_next >>> LOG2_TAPS;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      sum_reg <= '0;
      for (int i = 0; i < TAPS; i++)
      begin
        hist[i] <= '0;                                       // Window starts from silence
      end
    end
    else if (in_xfer)
    begin
      sum_reg <= sum_next;
      hist[0] <= s_beat.sample;
      for (int i = 1; i < TAPS; i++)
      begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      out_valid <= 1'b0;
    end
    else if (in_xfer)
    begin
      out_valid <= 1'b1;
    end
    else if (m_ready)
    begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (in_xfer)
    begin
      out_beat.sample <= cfg.smooth_en ? avg[SAMPLE_W-1:0] : s_beat.sample;
      out_beat.first  <= s_beat.first;                       // Flag passes through untouched
    end
  end

  assign m_beat  = out_beat;
  assign m_valid = out_valid;

endmodule

`default_nettype wire

// ==== logic/rate_pkg.sv ====
`default_nettype none

package rate_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rate configuration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int HOLD_W = 8;                    // Width of the repeat counter

  // Static setup, only changed while the pipeline is empty
  typedef struct packed {
    logic [HOLD_W-1:0] hold_count;              // Extra copies per input sample
    logic              smooth_en;               // Boxcar averaging on the output
  } rate_cfg_t;

endpackage

`default_nettype wire

// ==== logic/sample_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_fifo
  import sample_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 3
)
(
  input  logic         aclk,
  input  logic         aresetn,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  output logic         s_ready,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready
);

  localparam int DEPTH = 2**FIFO_DEPTH_LOG2;

  stream_beat_t               mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       push;
  logic                       pop;

  assign s_ready = (count != (FIFO_DEPTH_LOG2+1)'(DEPTH)); // Low as soon as the last slot fills
  assign m_valid = (count != '0);
  assign m_beat  = mem[rd_ptr];                            // Head shows without a read request

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;                           // Wraps at the depth
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                           // Push with pop keeps the level
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= s_beat;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sample_hold_interpolator.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_hold_interpolator
  import sample_pkg::*, rate_pkg::*;
(
  input  logic         aclk,
  input  logic         aresetn,
  input  rate_cfg_t    cfg,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  output logic         s_ready,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready
);

  stream_beat_t      int_beat_reg, int_beat_next;
  logic [HOLD_W-1:0] int_cntr_reg, int_cntr_next;
  logic              int_valid_reg, int_valid_next;
  logic              int_pop_reg, int_pop_next;

  logic head_fresh;
  logic last_copy;
  logic load;

  // A head under a pop pulse is already owned by the output register
  assign head_fresh = s_valid & ~int_pop_reg;
  assign last_copy  = (int_cntr_reg >= cfg.hold_count);
  assign load       = head_fresh & (~int_valid_reg | (m_ready & last_copy));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      int_cntr_reg  <= '0;
      int_valid_reg <= 1'b0;
      int_pop_reg   <= 1'b0;
    end
    else
    begin
      int_cntr_reg  <= int_cntr_next;
      int_valid_reg <= int_valid_next;
      int_pop_reg   <= int_pop_next;
    end
  end

  always_ff @(posedge aclk)
  begin
    int_beat_reg <= int_beat_next;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    int_beat_next  = int_beat_reg;
    int_cntr_next  = int_cntr_reg;
    int_valid_next = int_valid_reg;
    int_pop_next   = 1'b0;                             // Pop lasts a single cycle
    if (load)
    begin
      int_beat_next.sample = s_beat.sample;
      int_beat_next.first  = 1'b1;                     // Marks the start of a new sample
      int_cntr_next        = '0;
      int_valid_next       = 1'b1;
      int_pop_next         = 1'b1;
    end
    else if (int_valid_reg & m_ready)
    begin
      if (last_copy)
      begin
        int_valid_next = 1'b0;                         // Nothing waiting in the FIFO
      end
      else
      begin
        int_cntr_next       = int_cntr_reg + 1'b1;
        int_beat_next.first = 1'b0;
      end
    end
  end

  assign s_ready = int_pop_reg;
  assign m_beat  = int_beat_reg;
  assign m_valid = int_valid_reg;

endmodule

`default_nettype wire

// ==== logic/sample_pkg.sv ====
`default_nettype none

package sample_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sample format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int SAMPLE_W = 16;                 // Width of one DAC sample

  typedef logic signed [SAMPLE_W-1:0] sample_t; // Two's complement sample

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream beat
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One beat on any stream link between the stages
  typedef struct packed {
    sample_t sample;                            // Payload sample
    logic    first;                             // First copy of a held sample
  } stream_beat_t;

endpackage

`default_nettype wire

// ==== logic/upsampler_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module upsampler_top
  import sample_pkg::*, rate_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 3,
  parameter int LOG2_TAPS       = 2
)
(
  input  logic         aclk,
  input  logic         aresetn,
  input  rate_cfg_t    cfg,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  output logic         s_ready,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready
);

  stream_beat_t fifo_beat;
  logic         fifo_valid;
  logic         fifo_ready;
  stream_beat_t hold_beat;
  logic         hold_valid;
  logic         hold_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FIFO, then hold, then smooth
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  sample_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) i_sample_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (fifo_beat),
    .m_valid (fifo_valid),
    .m_ready (fifo_ready)
  );

  sample_hold_interpolator i_sample_hold_interpolator (
    .aclk    (aclk),
    .aresetn (aresetn),
    .cfg     (cfg),
    .s_beat  (fifo_beat),
    .s_valid (fifo_valid),
    .s_ready (fifo_ready),       // Pop pulse back to the FIFO
    .m_beat  (hold_beat),
    .m_valid (hold_valid),
    .m_ready (hold_ready)
  );

  boxcar_smoother #(
    .LOG2_TAPS (LOG2_TAPS)
  ) i_boxcar_smoother (
    .aclk    (aclk),
    .aresetn (aresetn),
    .cfg     (cfg),
    .s_beat  (hold_beat),
    .s_valid (hold_valid),
    .s_ready (hold_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

endmodule

`default_nettype wire

// ==== sim.f ====
logic/sample_pkg.sv
logic/rate_pkg.sv
logic/sample_fifo.sv
logic/sample_hold_interpolator.sv
logic/boxcar_smoother.sv
logic/upsampler_top.sv
verif/upsampler_tb.sv

// ==== verif/upsampler_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module upsampler_tb
  import sample_pkg::*, rate_pkg::*;
();

  localparam int FIFO_DEPTH_LOG2 = 3;
  localparam int LOG2_TAPS       = 2;
  localparam int FIFO_DEPTH      = 2**FIFO_DEPTH_LOG2;
  localparam int TAPS            = 2**LOG2_TAPS;
  localparam int HOLD_SAMPLES    = 8;
  localparam int SMOOTH_SAMPLES  = 16;
  localparam int STALL_SAMPLES   = 16;
  localparam int MAX_HOLD        = 5;
  localparam int TOTAL_SAMPLES   = 3*HOLD_SAMPLES + SMOOTH_SAMPLES + STALL_SAMPLES + FIFO_DEPTH + 3;
  localparam int CYCLE_LIMIT     = TOTAL_SAMPLES * (MAX_HOLD+1) * 4 + 200;

  logic         aclk;
  logic         aresetn;
  rate_cfg_t    cfg;
  stream_beat_t s_beat;
  logic         s_valid;
  logic         s_ready;
  stream_beat_t m_beat;
  logic         m_valid;
  logic         m_ready;

  rate_cfg_t    model_cfg;                    // Setting the model expands with
  int           window [TAPS];                // Last expanded samples, newest first
  stream_beat_t exp_q [$];
  logic         ready_pattern [256];
  logic         ready_random;
  int           cycle_count;

  upsampler_top #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
    .LOG2_TAPS       (LOG2_TAPS)
  ) i_upsampler_top (
    .aclk    (aclk),
    .aresetn (aresetn),
    .cfg     (cfg),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure reporting and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t want);
    if (got !== want)
    begin
      report_failure($sformatf("FAIL %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want)
    begin
      report_failure($sformatf("FAIL %s got %h expected %h", name, got, want));
    end
  endtask

  // Cycle limit and random output stalls
  always @(posedge aclk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      report_failure($sformatf("Timeout after %0d cycles with %0d output beats still missing",
                               cycle_count, exp_q.size()));
    end
    else if (ready_random)
    begin
      m_ready <= ready_pattern[cycle_count % 256];
    end
  end

  // Output monitor; a beat seen here transfers on the next rising edge
  always @(negedge aclk)
  begin
    stream_beat_t want;
    if (aresetn && m_valid && m_ready)
    begin
      if (exp_q.size() == 0)
      begin
        report_failure("An extra output beat appeared when none was expected");
      end
      else
      begin
        want = exp_q.pop_front();
        check_sample("m_beat.sample", m_beat.sample, want.sample);
        check_flag("m_beat.first", m_beat.first, want.first);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Each input sample becomes hold_count+1 output beats, optionally averaged
  task automatic expand_sample(input sample_t smp);
    stream_beat_t beat;
    int           sum;
    int           copies;
    copies = int'(model_cfg.hold_count) + 1;
    for (int k = 0; k < copies; k++)
    begin
      for (int t = TAPS-1; t > 0; t--)
      begin
        window[t] = window[t-1];
      end
      window[0] = int'(smp);
      sum = 0;
      for (int t = 0; t < TAPS; t++)
      begin
        sum += window[t];
      end
      beat.sample = model_cfg.smooth_en ? sample_t'(sum >>> LOG2_TAPS) : smp;
      beat.first  = (k == 0);
      exp_q.push_back(beat);
    end
  endtask

  task automatic apply_cfg(input logic [HOLD_W-1:0] hold, input logic smooth);
    @(posedge aclk);
    cfg       <= '{hold_count: hold, smooth_en: smooth};
    model_cfg  = '{hold_count: hold, smooth_en: smooth};
  endtask

  task automatic send_sample(input sample_t smp);
    @(posedge aclk);
    s_beat  <= '{sample: smp, first: 1'b0};    // The interpolator sets first itself
    s_valid <= 1'b1;
    @(negedge aclk);
    while (!s_ready)
    begin
      @(negedge aclk);
    end
    expand_sample(smp);
  endtask

  task automatic end_burst();
    @(posedge aclk);
    s_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
    begin
      @(posedge aclk);
    end
    repeat (12) @(posedge aclk);                // Room for a stray extra beat to show up
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset();
    @(negedge aclk);
    check_flag("s_ready", s_ready, 1'b1);
    check_flag("m_valid", m_valid, 1'b0);
    @(posedge aclk);
    m_ready <= 1'b1;
    repeat (16) @(posedge aclk);
  endtask

  task automatic test_hold_repeat();
    logic [HOLD_W-1:0] holds [3];
    holds = '{8'd0, 8'd1, 8'd5};
    foreach (holds[h])
    begin
      apply_cfg(holds[h], 1'b0);
      for (int i = 0; i < HOLD_SAMPLES; i++)
      begin
        send_sample(sample_t'($urandom));
      end
      end_burst();
      wait_drain();
    end
  endtask

  task automatic test_smoothing();
    apply_cfg(8'd3, 1'b1);
    for (int i = 0; i < 4; i++)
    begin
      send_sample(sample_t'(-8000));
    end
    for (int i = 0; i < 4; i++)
    begin
      send_sample(sample_t'(12000));
    end
    for (int i = 0; i < 8; i++)
    begin
      send_sample(sample_t'(-6000 + 1500*i));
    end
    end_burst();
    wait_drain();
  endtask

  task automatic test_backpressure();
    apply_cfg(8'd2, 1'b1);
    @(posedge aclk);
    ready_random <= 1'b1;
    for (int i = 0; i < STALL_SAMPLES; i++)
    begin
      if (($urandom % 2) == 1)
      begin
        end_burst();                            // Idle cycle on the input
      end
      send_sample(sample_t'($urandom));
    end
    end_burst();
    wait_drain();
    @(posedge aclk);
    ready_random <= 1'b0;
    @(posedge aclk);
    m_ready <= 1'b1;
  endtask

  task automatic test_fifo_full();
    logic    full_seen;
    sample_t smp;
    full_seen = 1'b0;
    apply_cfg(8'd1, 1'b0);
    @(posedge aclk);
    m_ready <= 1'b0;
    for (int i = 0; i < FIFO_DEPTH + 3; i++)
    begin
      smp = sample_t'($urandom);
      @(posedge aclk);
      s_beat  <= '{sample: smp, first: 1'b0};
      s_valid <= 1'b1;
      @(negedge aclk);
      if (!s_ready)
      begin
        full_seen = 1'b1;
        break;
      end
      expand_sample(smp);
    end
    end_burst();
    if (!full_seen)
    begin
      report_failure("s_ready never fell while the output was stalled");
    end
    @(posedge aclk);
    m_ready <= 1'b1;
    wait_drain();
  endtask

  initial
  begin
    void'($urandom(32'h4dd2));
    for (int i = 0; i < 256; i++)
    begin
      ready_pattern[i] = 1'(($urandom % 2) == 1);
    end
    for (int t = 0; t < TAPS; t++)
    begin
      window[t] = 0;
    end
    aresetn      = 1'b0;
    cfg          = '0;
    model_cfg    = '0;
    s_beat       = '0;
    s_valid      = 1'b0;
    m_ready      = 1'b0;
    ready_random = 1'b0;
    cycle_count  = 0;
    repeat (8) @(posedge aclk);
    aresetn <= 1'b1;
    test_reset();
    test_hold_repeat();
    test_smoothing();
    test_backpressure();
    test_fifo_full();
    if (exp_q.size() != 0)
    begin
      report_failure($sformatf("%0d expected output beats never arrived", exp_q.size()));
    end
    else
    begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
